// ==== verilog/spim_consts.svh ====
`ifndef SPIM_CONSTS_SVH
`define SPIM_CONSTS_SVH

// --------------------
// SPI master sizing
// --------------------

// clk cycles per sclk half period
`define SPIM_CLK_DIV 2

// Widest word in either direction
`define SPIM_W 32

// Bit count width, holds 0 to 32
`define SPIM_CW 6

`endif

// ==== verilog/spim_pkg.sv ====
`default_nettype none

`include "spim_consts.svh"

package spim_pkg;

  // Lane width per symbol
  typedef enum logic [1:0] {
    SPIM_SINGLE = 2'd0, // 1 lane
    SPIM_DUAL   = 2'd1, // 2 lanes
    SPIM_QUAD   = 2'd2  // 4 lanes
  } spim_mode_e;

  // --------------------
  // Host command
  // --------------------
  typedef struct packed {
    spim_mode_e          mode;
    logic [`SPIM_CW-1:0] tx_bits; // 0 skips transmit
    logic [`SPIM_CW-1:0] rx_bits; // 0 skips receive
    logic [`SPIM_W-1:0]  tx_data; // MSB goes out first
    logic [7:0]          tag;     // Echoed back in response
  } spim_cmd_t;

  // Response, rx_data right-aligned
  typedef struct packed {
    logic [7:0]         tag;
    logic [`SPIM_W-1:0] rx_data;
  } spim_rsp_t;

  // Symbols needed for a bit count
  function automatic logic [`SPIM_CW-1:0] spim_sym_count(input spim_mode_e          mode,
                                                         input logic [`SPIM_CW-1:0] bits);
    case (mode)
      SPIM_QUAD: return bits >> 2;
      SPIM_DUAL: return bits >> 1;
      default:   return bits;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== verilog/spim_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_clkgen import spim_pkg::*; (
  input  wire  clk,
  input  wire  rstn,
  input  wire  run_i,     // High keeps sclk toggling
  output logic sclk_o,
  output logic tx_edge_o, // On sclk fall, plus one at start
  output logic rx_edge_o  // On sclk rise
);

  localparam int CNT_W = $clog2(`SPIM_CLK_DIV) + 1;

  logic [CNT_W-1:0] div_cnt; // Half period counter
  logic             active;  // Set one clk after run rises
  logic             wrap;

  assign wrap = (div_cnt == CNT_W'(`SPIM_CLK_DIV - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      div_cnt   <= '0;
      active    <= 1'b0;
      sclk_o    <= 1'b0;
      tx_edge_o <= 1'b0;
      rx_edge_o <= 1'b0;
    end else if (!run_i) begin
      // sclk parked low while stopped
      div_cnt   <= '0;
      active    <= 1'b0;
      sclk_o    <= 1'b0;
      tx_edge_o <= 1'b0;
      rx_edge_o <= 1'b0;
    end else begin
      active    <= 1'b1;
      tx_edge_o <= !active || (wrap && sclk_o);  // Start strobe or falling sclk
      rx_edge_o <= active && wrap && !sclk_o;    // Rising sclk
      if (!active || wrap)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
      if (active && wrap)
        sclk_o <= !sclk_o;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spim_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_tx import spim_pkg::*; (
  input  wire                clk,
  input  wire                rstn,
  input  wire                start_i,   // Load word, begin transfer
  input  wire                tx_edge_i, // Shift strobe from clkgen
  input  wire spim_mode_e    mode_i,
  input  wire [`SPIM_CW-1:0] bits_i,    // Bits to send
  input  wire [`SPIM_W-1:0]  data_i,    // MSB first
  output logic [3:0]         sdo_o,     // Lanes 3..0
  output logic               done_o     // Last symbol held one period
);

  localparam logic [3:0] IDLE_LANES = 4'b1100; // Hold and WP lanes high

  typedef enum logic {IDLE, TRANSMIT} tx_state_e;

  tx_state_e           state;
  spim_mode_e          mode_q;
  logic [`SPIM_W-1:0]  shift_q;    // Word shifter
  logic [`SPIM_W-1:0]  shift_next;
  logic [`SPIM_CW-1:0] sym_cnt;    // Symbols put out so far
  logic [`SPIM_CW-1:0] sym_trgt;   // Bits divided by lane width
  logic [3:0]          sdo_next;
  logic                shift_en;

  // --------------------
  // Lane mapping
  // --------------------
  always_comb begin
    case (mode_q)
      SPIM_QUAD: begin
        sdo_next   = shift_q[`SPIM_W-1 -: 4];             // MSB on lane 3
        shift_next = {shift_q[`SPIM_W-5:0], 4'b0000};
      end
      SPIM_DUAL: begin
        sdo_next   = {2'b11, shift_q[`SPIM_W-1 -: 2]};    // MSB on lane 1
        shift_next = {shift_q[`SPIM_W-3:0], 2'b00};
      end
      default: begin
        sdo_next   = {2'b11, 1'b0, shift_q[`SPIM_W-1]};   // Lane 0 only
        shift_next = {shift_q[`SPIM_W-2:0], 1'b0};
      end
    endcase
  end

  // Done on the edge after the last symbol
  assign done_o   = (state == TRANSMIT) && tx_edge_i && (sym_cnt == sym_trgt);
  assign shift_en = (state == TRANSMIT) && tx_edge_i && (sym_cnt != sym_trgt);

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= IDLE;
      mode_q   <= SPIM_SINGLE;
      sym_cnt  <= '0;
      sym_trgt <= '0;
      sdo_o    <= IDLE_LANES;
    end else if (start_i) begin
      state    <= TRANSMIT;
      mode_q   <= mode_i;
      sym_cnt  <= '0;
      sym_trgt <= spim_sym_count(mode_i, bits_i);
    end else if (done_o) begin
      state <= IDLE;
      sdo_o <= IDLE_LANES;     // Back to idle levels
    end else if (shift_en) begin
      sdo_o   <= sdo_next;     // Updated clk after tx_edge
      sym_cnt <= sym_cnt + 1'b1;
    end
  end

  // Payload shifter
  always_ff @(posedge clk) begin
    if (start_i)
      shift_q <= data_i;
    else if (shift_en)
      shift_q <= shift_next;
  end

endmodule

`default_nettype wire

// ==== verilog/spim_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_rx import spim_pkg::*; (
  input  wire                clk,
  input  wire                rstn,
  input  wire                start_i,   // Clear word, begin receive
  input  wire                rx_edge_i, // Sample strobe from clkgen
  input  wire spim_mode_e    mode_i,
  input  wire [`SPIM_CW-1:0] bits_i,    // Bits to gather
  input  wire [3:0]          sdi_i,
  output logic               done_o,    // One clk after last sample
  output logic [`SPIM_W-1:0] word_o     // Right-aligned
);

  typedef enum logic {IDLE, RECEIVE} rx_state_e;

  rx_state_e           state;
  spim_mode_e          mode_q;
  logic [`SPIM_CW-1:0] sym_cnt;
  logic [`SPIM_CW-1:0] sym_trgt;
  logic [`SPIM_W-1:0]  word_next;
  logic                sample;
  logic                last_sym;

  assign sample   = (state == RECEIVE) && rx_edge_i;
  assign last_sym = (sym_cnt + 1'b1) == sym_trgt;

  // Shift in at the bottom
  always_comb begin
    case (mode_q)
      SPIM_QUAD: word_next = {word_o[`SPIM_W-5:0], sdi_i};        // Lanes 3..0
      SPIM_DUAL: word_next = {word_o[`SPIM_W-3:0], sdi_i[1:0]};   // Lanes 1..0
      default:   word_next = {word_o[`SPIM_W-2:0], sdi_i[1]};     // MISO on lane 1
    endcase
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= IDLE;
      mode_q   <= SPIM_SINGLE;
      sym_cnt  <= '0;
      sym_trgt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        state    <= RECEIVE;
        mode_q   <= mode_i;
        sym_cnt  <= '0;
        sym_trgt <= spim_sym_count(mode_i, bits_i);
      end else if (sample) begin
        sym_cnt <= sym_cnt + 1'b1;
        if (last_sym) begin
          state  <= IDLE;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i)
      word_o <= '0;
    else if (sample)
      word_o <= word_next;
  end

endmodule

`default_nettype wire

// ==== verilog/spim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_ctrl import spim_pkg::*; (
  input  wire               clk,
  input  wire               rstn,
  input  wire               cmd_valid_i, // One-cycle strobe, no ready
  input  wire spim_cmd_t    cmd_i,
  input  wire               tx_done_i,
  input  wire               rx_done_i,
  input  wire [`SPIM_W-1:0] rx_word_i,
  output logic              run_o,       // Enables clkgen
  output logic              tx_start_o,
  output logic              rx_start_o,
  output logic              csn_o,
  output logic              rsp_valid_o,
  output spim_rsp_t         rsp_o,
  output spim_cmd_t         cmd_o        // Latched command to engines
);

  typedef enum logic [1:0] {IDLE, TX, RX, END} ctrl_state_e;

  ctrl_state_e        state;
  logic [`SPIM_W-1:0] rx_data_q; // Zero when receive skipped
  logic               accept;

  assign accept = (state == IDLE) && cmd_valid_i; // Busy strobes dropped
  assign rsp_o  = '{tag: cmd_o.tag, rx_data: rx_data_q};

  // --------------------
  // Sequencer
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= IDLE;
      run_o       <= 1'b0;
      tx_start_o  <= 1'b0;
      rx_start_o  <= 1'b0;
      csn_o       <= 1'b1;
      rsp_valid_o <= 1'b0;
    end else begin
      tx_start_o  <= 1'b0;
      rx_start_o  <= 1'b0;
      rsp_valid_o <= 1'b0;
      case (state)
        IDLE: if (accept) begin
          csn_o <= 1'b0;
          if (cmd_i.tx_bits != '0) begin
            state      <= TX;
            run_o      <= 1'b1;
            tx_start_o <= 1'b1;
          end else if (cmd_i.rx_bits != '0) begin
            state      <= RX;  // Receive only
            run_o      <= 1'b1;
            rx_start_o <= 1'b1;
          end else begin
            state <= END;
          end
        end
        TX: if (tx_done_i) begin
          if (cmd_o.rx_bits != '0) begin
            state      <= RX;  // Clock keeps running
            rx_start_o <= 1'b1;
          end else begin
            state <= END;
            run_o <= 1'b0;
          end
        end
        RX: if (rx_done_i) begin
          state <= END;
          run_o <= 1'b0;       // sclk low before csn rises
        end
        END: begin
          state       <= IDLE;
          csn_o       <= 1'b1;
          rsp_valid_o <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Command and receive payload
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_o     <= cmd_i;
      rx_data_q <= '0;
    end else if (state == RX && rx_done_i) begin
      rx_data_q <= rx_word_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spim_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_top import spim_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  input  wire            cmd_valid_i,
  input  wire spim_cmd_t cmd_i,
  output logic           rsp_valid_o,
  output spim_rsp_t      rsp_o,
  output logic           sclk_o,
  output logic           csn_o,
  output logic [3:0]     sdo_o,
  input  wire [3:0]      sdi_i
);

  logic               run;
  logic               tx_edge;  // Shift strobe
  logic               rx_edge;  // Sample strobe
  logic               tx_start;
  logic               rx_start;
  logic               tx_done;
  logic               rx_done;
  logic [`SPIM_W-1:0] rx_word;
  spim_cmd_t          cmd;      // Latched command

  // --------------------
  // Clocking and sequencing
  // --------------------
  spim_clkgen u_clkgen (
    .clk       (clk),
    .rstn      (rstn),
    .run_i     (run),
    .sclk_o    (sclk_o),
    .tx_edge_o (tx_edge),
    .rx_edge_o (rx_edge)
  );

  spim_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .tx_done_i   (tx_done),
    .rx_done_i   (rx_done),
    .rx_word_i   (rx_word),
    .run_o       (run),
    .tx_start_o  (tx_start),
    .rx_start_o  (rx_start),
    .csn_o       (csn_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .cmd_o       (cmd)
  );

  // --------------------
  // Data engines
  // --------------------
  spim_tx u_tx (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (tx_start),
    .tx_edge_i (tx_edge),
    .mode_i    (cmd.mode),
    .bits_i    (cmd.tx_bits),
    .data_i    (cmd.tx_data),
    .sdo_o     (sdo_o),
    .done_o    (tx_done)
  );

  spim_rx u_rx (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (rx_start),
    .rx_edge_i (rx_edge),
    .mode_i    (cmd.mode),
    .bits_i    (cmd.rx_bits),
    .sdi_i     (sdi_i),
    .done_o    (rx_done),
    .word_o    (rx_word)
  );

endmodule

`default_nettype wire

// ==== testbench/spim_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module spim_props import spim_pkg::*; (
  input wire             clk,
  input wire             rstn,
  input wire             csn_i,
  input wire             sclk_i,
  input wire [3:0]       sdo_i,
  input wire             rsp_valid_i,
  input wire spim_mode_e mode_i       // Latched command mode
);

  logic fail_seen = 1'b0; // Sticky, polled from the testbench

  // --------------------
  // Handshake and chip select
  // --------------------
  a_rsp_pulse: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid_i |=> !rsp_valid_i)
    else begin
      $error("rsp_valid_o wider than one cycle");
      fail_seen = 1'b1;
    end

  a_csn_rise: assert property (@(posedge clk) disable iff (!rstn)
    $rose(csn_i) |-> rsp_valid_i)   // csn only released with the response
    else begin
      $error("csn_o rose without rsp_valid_o");
      fail_seen = 1'b1;
    end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rstn)
    csn_i |-> !sclk_i)
    else begin
      $error("sclk_o high while csn_o is high");
      fail_seen = 1'b1;
    end

  // Hold and WP lanes stay high unless quad is active
  a_idle_lanes: assert property (@(posedge clk) disable iff (!rstn)
    (csn_i || mode_i != SPIM_QUAD) |-> sdo_i[3:2] == 2'b11)
    else begin
      $error("sdo_o[3:2] not high outside a quad transfer");
      fail_seen = 1'b1;
    end

endmodule

bind spim_top spim_props u_props (
  .clk         (clk),
  .rstn        (rstn),
  .csn_i       (csn_o),
  .sclk_i      (sclk_o),
  .sdo_i       (sdo_o),
  .rsp_valid_i (rsp_valid_o),
  .mode_i      (cmd.mode)
);

`default_nettype wire

// ==== testbench/spim_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spim_consts.svh"

module spim_tb import spim_pkg::*; ();

  logic       clk;
  logic       rstn;
  logic       cmd_valid;
  spim_cmd_t  cmd;
  logic       rsp_valid;
  spim_rsp_t  rsp;
  logic       sclk;
  logic       csn;
  logic [3:0] sdo;
  logic [3:0] sdi;

  // Pattern table
  spim_cmd_t   pat_cmd[$];
  logic [31:0] pat_tx_exp[$];  // Expected capture right-aligned
  logic [31:0] pat_rx_data[$]; // Slave reply
  bit          pat_busy[$];    // Strobe again while busy

  // Transfer seen by the slave model
  spim_mode_e  cur_mode = SPIM_SINGLE;
  int          cur_tx_syms = 0;
  int          cur_rx_syms = 0;
  int          cur_rx_bits = 0;
  logic [31:0] cur_rx_data = '0;

  logic        csn_q = 1'b1;
  logic        sclk_q = 1'b0;
  int          tx_cnt = 0;
  int          rx_cnt = 0;
  logic [31:0] tx_cap = '0;    // Bits gathered from sdo
  logic [31:0] rx_sr = '0;     // Reply with MSB at bit 31

  int          rsp_count = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  spim_top u_spim_top (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .sclk_o      (sclk),
    .csn_o       (csn),
    .sdo_o       (sdo),
    .sdi_i       (sdi)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic int lane_count(input spim_mode_e mode);
    case (mode)
      SPIM_QUAD: return 4;
      SPIM_DUAL: return 2;
      default:   return 1;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    check_value("csn_o", csn, 1'b1);
    check_value("sclk_o", sclk, 1'b0);
    check_value("sdo_o", sdo, 4'b1100);
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    int          mode;
    int          tx_bits;
    int          rx_bits;
    int          busy;
    logic [31:0] tx_data;
    logic [31:0] tx_exp;
    logic [31:0] rx_data;
    logic [7:0]  tag;
    string       line;
    spim_cmd_t   c;
    fd = $fopen("testbench/spim_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/spim_patterns.txt");
      $display("Test failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#") begin  // Skip column notes
        n = $sscanf(line, "%d %d %d %h %h %h %h %d",
                    mode, tx_bits, rx_bits, tx_data, tx_exp, rx_data, tag, busy);
        if (n == 8) begin
          c.mode    = spim_mode_e'(mode);
          c.tx_bits = tx_bits[`SPIM_CW-1:0];
          c.rx_bits = rx_bits[`SPIM_CW-1:0];
          c.tx_data = tx_data;
          c.tag     = tag;
          pat_cmd.push_back(c);
          pat_tx_exp.push_back(tx_exp);
          pat_rx_data.push_back(rx_data);
          pat_busy.push_back(busy != 0);
        end
      end
    end
    $fclose(fd);
    if (pat_cmd.size() == 0) begin
      $display("No command lines found in testbench/spim_patterns.txt");
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Next reply symbol onto the active lanes with the others inverted
  task automatic drive_symbol();
    case (cur_mode)
      SPIM_QUAD: begin
        sdi   = rx_sr[31:28];
        rx_sr = rx_sr << 4;
      end
      SPIM_DUAL: begin
        sdi   = {~rx_sr[31:30], rx_sr[31:30]};
        rx_sr = rx_sr << 2;
      end
      default: begin
        sdi   = {~rx_sr[31], ~rx_sr[31], rx_sr[31], ~rx_sr[31]}; // MISO on lane 1
        rx_sr = rx_sr << 1;
      end
    endcase
    rx_cnt++;
  endtask

  // --------------------
  // SPI slave model
  // --------------------
  always @(negedge clk) begin
    if (csn_q && !csn) begin              // Transfer starts
      tx_cnt = 0;
      rx_cnt = 0;
      tx_cap = '0;
      rx_sr  = cur_rx_data << (32 - cur_rx_bits);
      if (cur_tx_syms == 0 && cur_rx_syms != 0)
        drive_symbol();                   // Receive only so first symbol goes up front
    end else if (!csn) begin
      if (sclk && !sclk_q && tx_cnt < cur_tx_syms) begin
        case (cur_mode)
          SPIM_QUAD: tx_cap = {tx_cap[27:0], sdo};
          SPIM_DUAL: tx_cap = {tx_cap[29:0], sdo[1:0]};
          default:   tx_cap = {tx_cap[30:0], sdo[0]};
        endcase
        tx_cnt++;
      end else if (!sclk && sclk_q && tx_cnt == cur_tx_syms && rx_cnt < cur_rx_syms) begin
        drive_symbol();                   // After falling sclk
      end
    end
    if (!csn && cur_mode != SPIM_QUAD)
      check_value("sdo_o[3:2]", sdo[3:2], 2'b11);
    csn_q  = csn;
    sclk_q = sclk;
  end

  // Timeout and response count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run exceeded %0d clk cycles", cycle_limit);
      $display("Test failed");
      $fatal(1);
    end
    if (rsp_valid)
      rsp_count <= rsp_count + 1;
  end

  always @(negedge clk) begin
    if (u_spim_top.u_props.fail_seen) begin
      $display("A bound property failed, see the assertion message above");
      $display("Test failed");
      $fatal(1);
    end
  end

  // --------------------
  // Command sequence
  // --------------------
  task automatic run_pattern(input int idx);
    spim_cmd_t   c;
    logic [31:0] rx_exp;
    int          lanes;
    int          base;
    c           = pat_cmd[idx];
    lanes       = lane_count(c.mode);
    cur_mode    = c.mode;
    cur_tx_syms = c.tx_bits / lanes;
    cur_rx_syms = c.rx_bits / lanes;
    cur_rx_bits = c.rx_bits;
    cur_rx_data = pat_rx_data[idx];
    if (c.rx_bits == 0)
      rx_exp = '0;
    else
      rx_exp = pat_rx_data[idx] & (32'hffff_ffff >> (32 - c.rx_bits));
    base      = rsp_count;
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    if (pat_busy[idx]) begin
      repeat (3) @(negedge clk);
      cmd.tag     = ~c.tag;     // Must never come back
      cmd.tx_data = ~c.tx_data;
      cmd_valid   = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
    end
    while (!rsp_valid)
      @(negedge clk);
    check_value("rsp_o.tag", rsp.tag, c.tag);
    check_value("rsp_o.rx_data", rsp.rx_data, rx_exp);
    check_value("sdo capture", tx_cap, pat_tx_exp[idx]);
    check_idle();
    repeat (2) @(negedge clk);
    check_value("response count", rsp_count, base + 1);
    check_idle();
  endtask

  initial begin
    rstn      = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    sdi       = 4'b0000;
    load_patterns();
    cycle_limit = pat_cmd.size() * (64 * 2 * `SPIM_CLK_DIV + 20);
    repeat (2) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_idle();
    foreach (pat_cmd[i])
      run_pattern(i);
    repeat (8) @(negedge clk);
    check_value("total responses", rsp_count, pat_cmd.size());
    if (u_spim_top.u_props.fail_seen) begin
      $display("A bound property failed during the run");
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/spim_pkg.sv
verilog/spim_clkgen.sv
verilog/spim_tx.sv
verilog/spim_rx.sv
verilog/spim_ctrl.sv
verilog/spim_top.sv
testbench/spim_props.sv
testbench/spim_tb.sv

// ==== testbench/spim_patterns.txt ====
# mode tx_bits rx_bits tx_data tx_expect rx_data tag busy_strobe
# mode 0 single, 1 dual, 2 quad; counts and busy decimal; data and tag hex
0 8 8 a5000000 000000a5 0000003c 11 0
0 32 8 deadbeef deadbeef 0000005a 12 0
1 16 16 1234abcd 00001234 0000c3a5 21 0
2 32 32 89abcdef 89abcdef 0f1e2d3c 41 0
2 8 12 7e000000 0000007e 000009b6 42 0
0 0 16 ffffffff 00000000 00008001 13 0
1 12 0 abc00000 00000abc 00001234 22 0
2 0 8 00000000 00000000 000000e7 43 0
0 4 4 90000000 00000009 00000006 14 1
1 8 24 3c000000 0000003c 005aa5c3 23 1
2 16 8 f00f0000 0000f00f 00000081 44 0
